/* Makefile */
# Verilator build and run of the text display testbench

VERILATOR  ?= verilator
TOP        := text_video_tb
RTL_TOP    := text_video_top
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
PASS_TEXT  := ALL CHECKS PASSED

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* hdl/font_ram.sv */
// font RAM, one byte per cell line, msb is the leftmost pixel
// single port, read data registered on en_i
`default_nettype none
`timescale 1ns/1ns

module font_ram (
    input  logic                         clk,
    input  logic                         en_i,
    input  logic                         we_i,
    input  video_timing_pkg::font_addr_t addr_i,
    input  logic [7:0]                   wdata_i,
    output logic [7:0]                   rdata_o
);
    logic [7:0] mem [video_timing_pkg::FONT_DEPTH];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];
        end
    end
endmodule

`default_nettype wire

/* hdl/text_video_top.sv */
// text display top
// engine, memory arbiter, video RAM and font RAM
`default_nettype none
`timescale 1ns/1ns

module text_video_top (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           enable_i,
    input  logic                           reg_wr_i,
    input  logic [2:0]                     reg_num_i,
    input  video_regs_pkg::vgen_reg_word_u reg_data_i,
    output logic [15:0]                    reg_rdata_o,
    input  logic                           host_wr_valid_i,
    input  video_regs_pkg::host_wr_req_s   host_wr_i,
    output logic                           host_wr_ready_o,
    output logic [3:0]                     pal_index_o,
    output logic                           hsync_o,
    output logic                           vsync_o,
    output logic                           dv_de_o
);
    // engine requests
    logic                         vid_vram_sel, vid_font_sel;
    video_timing_pkg::vram_addr_t vid_vram_addr;
    video_timing_pkg::font_addr_t vid_font_addr;
    // memory ports
    logic                         vram_en, vram_we, font_en, font_we;
    video_timing_pkg::vram_addr_t vram_addr;
    video_timing_pkg::font_addr_t font_addr;
    logic [15:0]                  vram_wdata, vram_rdata;
    logic [7:0]                   font_wdata, font_rdata;

    video_gen u_video_gen (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i),
        .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
        .vram_data_i(vram_rdata), .fontram_data_i(font_rdata), .reg_rdata_o(reg_rdata_o),
        .vram_sel_o(vid_vram_sel), .vram_addr_o(vid_vram_addr),
        .fontram_sel_o(vid_font_sel), .fontram_addr_o(vid_font_addr),
        .pal_index_o(pal_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    vram_arbiter u_arbiter (
        .clk(clk), .reset_i(reset_i),
        .vid_vram_sel_i(vid_vram_sel), .vid_vram_addr_i(vid_vram_addr),
        .vid_font_sel_i(vid_font_sel), .vid_font_addr_i(vid_font_addr),
        .host_wr_valid_i(host_wr_valid_i), .host_wr_i(host_wr_i),
        .host_wr_ready_o(host_wr_ready_o),
        .vram_en_o(vram_en), .vram_we_o(vram_we), .vram_addr_o(vram_addr),
        .vram_wdata_o(vram_wdata),
        .font_en_o(font_en), .font_we_o(font_we), .font_addr_o(font_addr),
        .font_wdata_o(font_wdata)
    );

    vram u_vram (
        .clk(clk), .en_i(vram_en), .we_i(vram_we), .addr_i(vram_addr),
        .wdata_i(vram_wdata), .rdata_o(vram_rdata)
    );

    font_ram u_font_ram (
        .clk(clk), .en_i(font_en), .we_i(font_we), .addr_i(font_addr),
        .wdata_i(font_wdata), .rdata_o(font_rdata)
    );
endmodule

`default_nettype wire

/* hdl/video_gen.sv */
// text mode video engine
// raster sync machines, char and font fetch sequencer, pixel shifter, config regs
`default_nettype none
`timescale 1ns/1ns

module video_gen (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           enable_i,        // takes effect at end of frame
    input  logic                           reg_wr_i,
    input  logic [2:0]                     reg_num_i,
    input  video_regs_pkg::vgen_reg_word_u reg_data_i,
    input  logic [15:0]                    vram_data_i,     // attr high, char low
    input  logic [7:0]                     fontram_data_i,
    output logic [15:0]                    reg_rdata_o,
    output logic                           vram_sel_o,
    output video_timing_pkg::vram_addr_t   vram_addr_o,
    output logic                           fontram_sel_o,
    output video_timing_pkg::font_addr_t   fontram_addr_o,
    output logic [3:0]                     pal_index_o,
    output logic                           hsync_o,
    output logic                           vsync_o,
    output logic                           dv_de_o
);
    typedef enum logic [1:0] {ST_FRONT, ST_SYNC, ST_BACK, ST_VISIBLE} raster_state_e;

    raster_state_e h_state, h_state_next, v_state, v_state_next;
    video_timing_pkg::hcount_t h_count, h_limit, fetch_toggle;
    video_timing_pkg::vcount_t v_count, v_limit;
    logic h_last, v_last;                           // last pixel of line, of frame
    logic mem_fetch, mem_fetch_next;
    logic tg_enable;

    // config registers
    video_timing_pkg::vram_addr_t text_start_addr, text_line_width;
    logic [4:0] fine_scrolly;
    logic [3:0] font_height;
    logic       v_double;

    // fetch and pixel pipeline
    video_timing_pkg::vram_addr_t text_addr, text_line_addr;
    logic [2:0] char_x;                             // pixel within the cell
    logic [4:0] char_y;                             // cell line, extra low bit for v_double
    logic       font_valid;                         // font data arriving this cycle
    logic [7:0] attr_save, attr_next, text_color;
    logic [7:0] font_next, font_shift;

    always_comb begin
        case (h_state)
            ST_FRONT: h_limit = video_timing_pkg::H_FRONT_END;
            ST_SYNC:  h_limit = video_timing_pkg::H_SYNC_END;
            ST_BACK:  h_limit = video_timing_pkg::H_BACK_END;
            default:  h_limit = video_timing_pkg::H_LINE_END;
        endcase
        case (v_state)
            ST_FRONT: v_limit = video_timing_pkg::V_FRONT_END;
            ST_SYNC:  v_limit = video_timing_pkg::V_SYNC_END;
            ST_BACK:  v_limit = video_timing_pkg::V_FRAME_END;
            default:  v_limit = video_timing_pkg::V_VISIBLE_END;
        endcase
        h_last = (h_state == ST_VISIBLE) && (h_count == h_limit);
        v_last = h_last && (v_state == ST_BACK) && (v_count == v_limit);
        h_state_next = (h_count == h_limit) ? raster_state_e'(h_state + 2'd1) : h_state;
        v_state_next = (h_last && v_count == v_limit) ? raster_state_e'(v_state + 2'd1)
                                                      : v_state;
        // window opens early and closes once the last visible cell is fetched
        fetch_toggle   = mem_fetch ? video_timing_pkg::H_MEM_END : video_timing_pkg::H_MEM_BEGIN;
        mem_fetch_next = (v_state == ST_VISIBLE && h_count == fetch_toggle) ? ~mem_fetch
                                                                            : mem_fetch;
    end

    // font address straight from the arriving char word, 16 line fonts hold 128 chars
    assign fontram_addr_o = font_height[3] ? {vram_data_i[6:0], char_y[4:1]}
                                           : {vram_data_i[7:0], char_y[3:1]};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state        <= ST_FRONT;
            v_state        <= ST_VISIBLE;
            h_count        <= '0;
            v_count        <= '0;
            mem_fetch      <= 1'b0;
            tg_enable      <= 1'b0;             // dark until first frame end
            char_x         <= '0;
            char_y         <= '0;
            text_addr      <= '0;
            text_line_addr <= '0;
            vram_sel_o     <= 1'b0;
            fontram_sel_o  <= 1'b0;
            font_valid     <= 1'b0;
            hsync_o        <= ~video_timing_pkg::H_SYNC_POLARITY;
            vsync_o        <= ~video_timing_pkg::V_SYNC_POLARITY;
            dv_de_o        <= 1'b0;
        end else begin
            h_state   <= h_state_next;
            v_state   <= v_state_next;
            h_count   <= h_last ? '0 : h_count + 1'b1;
            mem_fetch <= mem_fetch_next;
            if (h_last) begin
                v_count <= v_last ? '0 : v_count + 1'b1;
            end

            char_x <= char_x + 3'd1;
            if (~mem_fetch && mem_fetch_next) begin
                char_x <= '0;                   // phase cells to the window start
            end

            // vram, then font one cycle later, then data lands in the next buffer
            vram_sel_o    <= tg_enable && mem_fetch && (char_x == 3'd0);
            fontram_sel_o <= vram_sel_o;
            font_valid    <= fontram_sel_o;
            if (mem_fetch && char_x == 3'd0) begin
                text_addr <= text_addr + 1'b1;
            end

            if (h_last) begin
                text_addr <= text_line_addr;    // repeat the row for the next cell line
                if (char_y == {font_height, v_double}) begin
                    char_y         <= '0;
                    text_line_addr <= text_line_addr + text_line_width;
                    text_addr      <= text_line_addr + text_line_width;
                end else begin
                    char_y <= char_y + (v_double ? 5'd1 : 5'd2);
                end
            end

            if (v_last) begin
                tg_enable      <= enable_i;
                char_y         <= v_double ? fine_scrolly : {fine_scrolly[3:0], 1'b0};
                text_addr      <= text_start_addr;
                text_line_addr <= text_start_addr;
            end

            hsync_o <= (h_state == ST_SYNC) ? video_timing_pkg::H_SYNC_POLARITY
                                            : ~video_timing_pkg::H_SYNC_POLARITY;
            vsync_o <= (v_state == ST_SYNC) ? video_timing_pkg::V_SYNC_POLARITY
                                            : ~video_timing_pkg::V_SYNC_POLARITY;
            dv_de_o <= tg_enable && (h_state == ST_VISIBLE) && (v_state == ST_VISIBLE);
        end
    end

    // pixel datapath
    always_ff @(posedge clk) begin
        if (mem_fetch && char_x == 3'd0) begin
            vram_addr_o <= text_addr;
        end
        if (fontram_sel_o) begin
            attr_save <= vram_data_i[15:8];     // hold attr while the font byte is read
        end
        if (font_valid) begin
            font_next <= fontram_data_i;        // one cell ahead of the shifter
            attr_next <= attr_save;
        end
        if (char_x == video_timing_pkg::SHIFT_LOAD_PHASE) begin
            font_shift <= font_next;
            text_color <= attr_next;
        end else begin
            font_shift <= {font_shift[6:0], 1'b0};  // msb is the current pixel
        end
        pal_index_o <= font_shift[7] ? text_color[3:0] : text_color[7:4];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            text_start_addr <= '0;
            text_line_width <= video_timing_pkg::vram_addr_t'(video_timing_pkg::CHARS_WIDE);
            fine_scrolly    <= '0;
            font_height     <= 4'd7;            // 8 line cells
            v_double        <= 1'b0;
        end else if (reg_wr_i) begin
            case (reg_num_i)
                video_regs_pkg::REG_DISPSTART:
                    text_start_addr <= video_timing_pkg::vram_addr_t'(reg_data_i.raw);
                video_regs_pkg::REG_LINEWIDTH:
                    text_line_width <= video_timing_pkg::vram_addr_t'(reg_data_i.raw);
                video_regs_pkg::REG_SCROLLY:   fine_scrolly <= reg_data_i.scroll.fine_scrolly;
                video_regs_pkg::REG_FONTCTRL:  font_height  <= reg_data_i.ctrl.font_height;
                video_regs_pkg::REG_GFXCTRL:   v_double     <= reg_data_i.ctrl.v_double;
                default: ;
            endcase
        end
    end

    // read back, one cycle behind reg_num_i
    always_ff @(posedge clk) begin
        case (reg_num_i[1:0])
            2'd0:    reg_rdata_o <= 16'(video_timing_pkg::VISIBLE_WIDTH);
            2'd1:    reg_rdata_o <= 16'(video_timing_pkg::VISIBLE_HEIGHT);
            2'd2:    reg_rdata_o <= video_regs_pkg::FEATURE_WORD;
            default: reg_rdata_o <= {v_state != ST_VISIBLE, h_state != ST_VISIBLE, 14'(v_count)};
        endcase
    end
endmodule

`default_nettype wire

/* hdl/video_regs_pkg.sv */
// register map and host write types of the text display
// one packed union decodes a register write as scroll or control layout
`default_nettype none

package video_regs_pkg;
    // write register numbers
    localparam logic [2:0] REG_DISPSTART = 3'd0;    // text start word address
    localparam logic [2:0] REG_LINEWIDTH = 3'd1;    // words per text row
    localparam logic [2:0] REG_SCROLLY   = 3'd2;    // Y fine scroll
    localparam logic [2:0] REG_FONTCTRL  = 3'd3;    // font height
    localparam logic [2:0] REG_GFXCTRL   = 3'd4;    // vertical pixel double

    localparam logic [15:0] FEATURE_WORD = 16'h8001;

    typedef struct packed {
        logic [10:0] rsvd;
        logic [4:0]  fine_scrolly;                  // low bit is half a line with v_double
    } scroll_view_s;

    typedef struct packed {
        logic [10:0] rsvd;
        logic        v_double;                      // GFXCTRL
        logic [3:0]  font_height;                   // FONTCTRL, last line of the cell
    } ctrl_view_s;

    typedef union packed {
        logic [15:0]  raw;                          // start address, line width
        scroll_view_s scroll;
        ctrl_view_s   ctrl;
    } vgen_reg_word_u;

    typedef enum logic {
        TGT_VRAM = 1'b0,
        TGT_FONT = 1'b1
    } mem_target_e;

    typedef struct packed {
        mem_target_e target;
        logic [15:0] addr;
        logic [15:0] data;                          // font writes use the low byte
    } host_wr_req_s;
endpackage

`default_nettype wire

/* hdl/video_timing_pkg.sv */
// raster geometry for the small simulation display
// sync polarities, memory sizes and the fetch window of the text engine
`default_nettype none

package video_timing_pkg;
    localparam int VISIBLE_WIDTH   = 32;                // pixels per visible line
    localparam int VISIBLE_HEIGHT  = 16;                // visible lines
    localparam int H_FRONT_PORCH   = 4;
    localparam int H_SYNC_PULSE    = 4;
    localparam int OFFSCREEN_WIDTH = 16;                // porches and sync, left of visible
    localparam int TOTAL_WIDTH     = VISIBLE_WIDTH + OFFSCREEN_WIDTH;
    localparam int V_FRONT_PORCH   = 1;
    localparam int V_SYNC_PULSE    = 2;
    localparam int TOTAL_HEIGHT    = 21;                // back porch fills the rest
    localparam logic H_SYNC_POLARITY = 1'b0;            // active low
    localparam logic V_SYNC_POLARITY = 1'b0;            // active low
    localparam int CHARS_WIDE      = VISIBLE_WIDTH / 8; // 8 pixel wide cells

    localparam int VRAM_AW    = 8;
    localparam int FONT_AW    = 11;
    localparam int VRAM_DEPTH = 2**VRAM_AW;
    localparam int FONT_DEPTH = 2**FONT_AW;
    localparam int H_COUNT_W  = $clog2(TOTAL_WIDTH);
    localparam int V_COUNT_W  = $clog2(TOTAL_HEIGHT);

    typedef logic [H_COUNT_W-1:0] hcount_t;
    typedef logic [V_COUNT_W-1:0] vcount_t;
    typedef logic [VRAM_AW-1:0]   vram_addr_t;
    typedef logic [FONT_AW-1:0]   font_addr_t;

    // last count of each raster state, lines start with the front porch
    localparam hcount_t H_FRONT_END   = hcount_t'(H_FRONT_PORCH - 1);
    localparam hcount_t H_SYNC_END    = hcount_t'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
    localparam hcount_t H_BACK_END    = hcount_t'(OFFSCREEN_WIDTH - 1);
    localparam hcount_t H_LINE_END    = hcount_t'(TOTAL_WIDTH - 1);
    // frames start with visible lines, blanking at the bottom
    localparam vcount_t V_VISIBLE_END = vcount_t'(VISIBLE_HEIGHT - 1);
    localparam vcount_t V_FRONT_END   = vcount_t'(VISIBLE_HEIGHT + V_FRONT_PORCH - 1);
    localparam vcount_t V_SYNC_END    = vcount_t'(VISIBLE_HEIGHT + V_FRONT_PORCH
                                                  + V_SYNC_PULSE - 1);
    localparam vcount_t V_FRAME_END   = vcount_t'(TOTAL_HEIGHT - 1);

    // fetch window, opens 13 pixels before visible to cover the pipeline depth
    localparam hcount_t H_MEM_BEGIN      = hcount_t'(OFFSCREEN_WIDTH - 13);
    localparam hcount_t H_MEM_END        = hcount_t'(TOTAL_WIDTH - 16);
    localparam logic [2:0] SHIFT_LOAD_PHASE = 3'd3;    // char_x when the shifter reloads
endpackage

`default_nettype wire

/* hdl/vram.sv */
// video RAM, 16-bit char and attribute words
// single port, read data registered on en_i
`default_nettype none
`timescale 1ns/1ns

module vram (
    input  logic                         clk,
    input  logic                         en_i,
    input  logic                         we_i,
    input  video_timing_pkg::vram_addr_t addr_i,
    input  logic [15:0]                  wdata_i,
    output logic [15:0]                  rdata_o
);
    logic [15:0] mem [video_timing_pkg::VRAM_DEPTH];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];     // old data on a write cycle
        end
    end
endmodule

`default_nettype wire

/* hdl/vram_arbiter.sv */
// memory arbiter between the text engine and the host writer
// engine always wins, host writes go into cycles the engine leaves free
`default_nettype none
`timescale 1ns/1ns

module vram_arbiter (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         vid_vram_sel_i,
    input  video_timing_pkg::vram_addr_t vid_vram_addr_i,
    input  logic                         vid_font_sel_i,
    input  video_timing_pkg::font_addr_t vid_font_addr_i,
    input  logic                         host_wr_valid_i,
    input  video_regs_pkg::host_wr_req_s host_wr_i,
    output logic                         host_wr_ready_o,
    output logic                         vram_en_o,
    output logic                         vram_we_o,
    output video_timing_pkg::vram_addr_t vram_addr_o,
    output logic [15:0]                  vram_wdata_o,
    output logic                         font_en_o,
    output logic                         font_we_o,
    output video_timing_pkg::font_addr_t font_addr_o,
    output logic [7:0]                   font_wdata_o
);
    logic host_ok;          // low through reset
    logic tgt_font;
    logic tgt_busy;         // engine owns the host's target this cycle
    logic host_fire;        // one write per valid/ready handshake

    always_ff @(posedge clk) begin
        if (reset_i) begin
            host_ok <= 1'b0;
        end else begin
            host_ok <= 1'b1;
        end
    end

    always_comb begin
        tgt_font        = (host_wr_i.target == video_regs_pkg::TGT_FONT);
        tgt_busy        = tgt_font ? vid_font_sel_i : vid_vram_sel_i;
        host_wr_ready_o = host_ok && !tgt_busy;     // independent of valid
        host_fire       = host_wr_valid_i && host_wr_ready_o;

        vram_en_o    = vid_vram_sel_i || (host_fire && !tgt_font);
        vram_we_o    = host_fire && !tgt_font;      // fire implies the engine is off vram
        vram_addr_o  = vid_vram_sel_i ? vid_vram_addr_i
                                      : video_timing_pkg::vram_addr_t'(host_wr_i.addr);
        vram_wdata_o = host_wr_i.data;

        font_en_o    = vid_font_sel_i || (host_fire && tgt_font);
        font_we_o    = host_fire && tgt_font;
        font_addr_o  = vid_font_sel_i ? vid_font_addr_i
                                      : video_timing_pkg::font_addr_t'(host_wr_i.addr);
        font_wdata_o = host_wr_i.data[7:0];
    end
endmodule

`default_nettype wire

/* verif/text_video_properties.sv */
// text display assertions, bound into the top level
// host handshake, engine priority, reset state and hsync width
`default_nettype none
`timescale 1ns/1ns

module text_video_properties (
    input logic                         clk,
    input logic                         reset_i,
    input logic                         host_wr_valid_i,
    input video_regs_pkg::host_wr_req_s host_wr_i,
    input logic                         host_wr_ready_o,
    input logic                         vid_vram_sel_i,
    input logic                         vid_font_sel_i,
    input logic                         vram_we_i,
    input logic                         font_we_i,
    input logic                         hsync_o,
    input logic                         dv_de_o
);
    logic       hs_active;
    logic [7:0] hs_len;                 // active cycles so far in the current pulse

    assign hs_active = (hsync_o == video_timing_pkg::H_SYNC_POLARITY);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_len <= '0;
        end else if (hs_active) begin
            hs_len <= hs_len + 8'd1;
        end else begin
            hs_len <= '0;
        end
    end

    // host holds its request until accepted
    host_hold: assert property (@(posedge clk) disable iff (reset_i)
        host_wr_valid_i && !host_wr_ready_o |=> host_wr_valid_i && $stable(host_wr_i))
        else $error("host request changed before ready");

    // a host write never lands in a memory cycle the engine reads
    engine_vram_first: assert property (@(posedge clk) disable iff (reset_i)
        vid_vram_sel_i |-> !vram_we_i)
        else $error("host write to vram while the engine reads it");

    engine_font_first: assert property (@(posedge clk) disable iff (reset_i)
        vid_font_sel_i |-> !font_we_i)
        else $error("host write to font ram while the engine reads it");

    dark_after_reset: assert property (@(posedge clk)
        reset_i |=> !dv_de_o && !vid_vram_sel_i && !vid_font_sel_i && !host_wr_ready_o)
        else $error("display, engine selects or host ready active right after reset");

    hsync_width: assert property (@(posedge clk) disable iff (reset_i)
        !hs_active && $past(hs_active) |-> hs_len == 8'(video_timing_pkg::H_SYNC_PULSE))
        else $error("hsync pulse has the wrong length");
endmodule

bind text_video_top text_video_properties u_props (
    .clk(clk), .reset_i(reset_i),
    .host_wr_valid_i(host_wr_valid_i), .host_wr_i(host_wr_i),
    .host_wr_ready_o(host_wr_ready_o),
    .vid_vram_sel_i(vid_vram_sel), .vid_font_sel_i(vid_font_sel),
    .vram_we_i(vram_we), .font_we_i(font_we),
    .hsync_o(hsync_o), .dv_de_o(dv_de_o)
);

`default_nettype wire

/* verif/text_video_tb.sv */
// testbench for the text display
// loads both memories through the host port, then checks frames from a table of settings
`default_nettype none
`timescale 1ns/1ns

module text_video_tb;
    localparam int NUM_ROWS = 6;
    localparam longint FRAME_NS = video_timing_pkg::TOTAL_WIDTH
                                  * video_timing_pkg::TOTAL_HEIGHT * 40;

    typedef struct packed {
        logic [7:0] start;      // text start word
        logic [7:0] width;      // words per row
        logic [4:0] scroll;     // fine scroll Y
        logic [3:0] fheight;    // last line of the cell
        logic       vdbl;
        logic [1:0] settle;     // extra frames before the check
    } row_s;

    row_s rows [NUM_ROWS] = '{
        '{8'd0,   8'd4, 5'd0, 4'd7, 1'b0, 2'd1},     // reset defaults
        '{8'd37,  8'd9, 5'd0, 4'd7, 1'b0, 2'd1},
        '{8'd250, 8'd6, 5'd3, 4'd7, 1'b0, 2'd1},     // address wraps
        '{8'd16,  8'd5, 5'd2, 4'd4, 1'b0, 2'd1},     // 5 line cells
        '{8'd8,   8'd4, 5'd5, 4'd7, 1'b1, 2'd1},     // scroll in half lines
        '{8'd100, 8'd7, 5'd1, 4'd2, 1'b1, 2'd2}
    };

    logic                           clk;
    logic                           reset_i;
    logic                           enable_i;
    logic                           reg_wr_i;
    logic [2:0]                     reg_num_i;
    video_regs_pkg::vgen_reg_word_u reg_data_i;
    logic [15:0]                    reg_rdata_o;
    logic                           host_wr_valid_i;
    video_regs_pkg::host_wr_req_s   host_wr_i;
    logic                           host_wr_ready_o;
    logic [3:0]                     pal_index_o;
    logic                           hsync_o, vsync_o, dv_de_o;

    logic [15:0] vram_model [256];
    logic [7:0]  font_model [2048];
    int          error_count = 0;

    text_video_top u_dut (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i),
        .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
        .reg_rdata_o(reg_rdata_o),
        .host_wr_valid_i(host_wr_valid_i), .host_wr_i(host_wr_i),
        .host_wr_ready_o(host_wr_ready_o),
        .pal_index_o(pal_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog sized from the frames each table row needs plus memory loading
    initial begin
        longint limit;
        limit = (NUM_ROWS * 4 + 4) * FRAME_NS + 4 * 512 * 4 * 40;
        #(limit);
        $display("timeout: frames or host writes did not complete in time");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s actual 0x%0h expected 0x%0h", name, act, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input logic [2:0] num, input video_regs_pkg::vgen_reg_word_u data);
        @(posedge clk);
        #2;
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(posedge clk);
        #2;
        reg_wr_i  = 1'b0;
        reg_num_i = 3'd3;                       // park on status
    endtask

    task automatic read_reg(input logic [2:0] num, input logic [15:0] exp);
        @(posedge clk);
        #2;
        reg_num_i = num;
        @(posedge clk);
        @(negedge clk);
        check_value($sformatf("reg_rdata_o[%0d]", num), reg_rdata_o, exp);
    endtask

    task automatic host_write(input video_regs_pkg::mem_target_e tgt, input logic [15:0] addr,
                              input logic [15:0] data);
        int   gap;
        logic rdy;
        gap = $urandom % 3;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #2;
        host_wr_valid_i  = 1'b1;
        host_wr_i.target = tgt;
        host_wr_i.addr   = addr;
        host_wr_i.data   = data;
        rdy = 1'b0;
        while (!rdy) begin
            @(negedge clk);
            rdy = host_wr_ready_o;              // accepted at the coming edge
            @(posedge clk);
        end
        #2;
        host_wr_valid_i = 1'b0;
    endtask

    function automatic logic [3:0] expected_pixel(input row_s r, input int x, input int y);
        int          per, c, cell_row, lin, addr;
        logic [15:0] w;
        logic [7:0]  fb;
        c = int'(r.scroll) + y;
        if (r.vdbl) begin
            per      = 2 * (int'(r.fheight) + 1);
            cell_row = c / per;
            lin      = (c % per) / 2;
        end else begin
            per      = int'(r.fheight) + 1;
            cell_row = c / per;
            lin      = c % per;
        end
        addr = (int'(r.start) + cell_row * int'(r.width) + x / 8) % 256;
        w    = vram_model[addr];
        fb   = font_model[int'(w[7:0]) * 8 + lin];
        return fb[7 - (x % 8)] ? w[11:8] : w[15:12];
    endfunction

    // skip the rest of the current frame, returns at the next vsync start
    task automatic align_to_vsync();
        @(negedge clk);
        while (vsync_o == video_timing_pkg::V_SYNC_POLARITY) @(negedge clk);
        while (vsync_o != video_timing_pkg::V_SYNC_POLARITY) @(negedge clk);
    endtask

    // one frame from vsync start to the next vsync start
    task automatic run_frame(input bit check_pixels, input row_s r, output int de_count);
        int sync_cycles;
        int n;
        while (vsync_o != video_timing_pkg::V_SYNC_POLARITY) @(negedge clk);
        sync_cycles = 0;
        while (vsync_o == video_timing_pkg::V_SYNC_POLARITY) begin
            sync_cycles++;
            check_value("status vblank", reg_rdata_o[15], 1'b1);
            @(negedge clk);
        end
        check_value("vsync_o lines", sync_cycles / video_timing_pkg::TOTAL_WIDTH,
                    video_timing_pkg::V_SYNC_PULSE);
        check_value("vsync_o cycles", sync_cycles,
                    video_timing_pkg::V_SYNC_PULSE * video_timing_pkg::TOTAL_WIDTH);
        n = 0;
        while (vsync_o != video_timing_pkg::V_SYNC_POLARITY) begin
            if (dv_de_o) begin
                check_value("status vblank", reg_rdata_o[15], 1'b0);
                if (check_pixels) begin
                    check_value($sformatf("pal_index_o x%0d y%0d", n % 32, n / 32),
                                pal_index_o, expected_pixel(r, n % 32, n / 32));
                end
                n++;
            end
            @(negedge clk);
        end
        de_count = n;
    endtask

    initial begin
        video_regs_pkg::vgen_reg_word_u w;
        int   de_count;
        row_s r;
        void'($urandom(72261));
        reset_i         = 1'b1;
        enable_i        = 1'b0;
        reg_wr_i        = 1'b0;
        reg_num_i       = 3'd0;
        reg_data_i      = '0;
        host_wr_valid_i = 1'b0;
        host_wr_i       = '0;
        repeat (4) @(posedge clk);
        #2;
        reset_i = 1'b0;

        read_reg(3'd0, 16'(video_timing_pkg::VISIBLE_WIDTH));
        read_reg(3'd1, 16'(video_timing_pkg::VISIBLE_HEIGHT));
        read_reg(3'd2, video_regs_pkg::FEATURE_WORD);
        @(posedge clk);
        #2;
        reg_num_i = 3'd3;
        run_frame(1'b0, rows[0], de_count);
        check_value("dv_de_o count dark", de_count, 0);

        @(posedge clk);
        #2;
        enable_i = 1'b1;                        // engine fetches while the host loads
        for (int i = 0; i < 256; i++) begin
            vram_model[i] = {8'($urandom), 8'($urandom % 32)};   // chars 0 to 31 only
            host_write(video_regs_pkg::TGT_VRAM, 16'(i), vram_model[i]);
        end
        for (int i = 0; i < 256; i++) begin
            font_model[i] = 8'($urandom);
            host_write(video_regs_pkg::TGT_FONT, 16'(i), {8'hA5, font_model[i]});
        end

        for (int k = 0; k < NUM_ROWS; k++) begin
            r = rows[k];
            w = '0;
            w.raw = {8'd0, r.start};
            write_reg(video_regs_pkg::REG_DISPSTART, w);
            w.raw = {8'd0, r.width};
            write_reg(video_regs_pkg::REG_LINEWIDTH, w);
            w = '0;
            w.scroll.fine_scrolly = r.scroll;
            write_reg(video_regs_pkg::REG_SCROLLY, w);
            w = '0;
            w.ctrl.font_height = r.fheight;
            write_reg(video_regs_pkg::REG_FONTCTRL, w);
            w = '0;
            w.ctrl.v_double = r.vdbl;
            write_reg(video_regs_pkg::REG_GFXCTRL, w);
            align_to_vsync();
            for (int s = 0; s < int'(r.settle); s++) begin
                run_frame(1'b0, r, de_count);
            end
            run_frame(1'b1, r, de_count);
            check_value("dv_de_o count", de_count,
                        video_timing_pkg::VISIBLE_WIDTH * video_timing_pkg::VISIBLE_HEIGHT);
        end

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end
endmodule

`default_nettype wire

/* vlog.f */
hdl/video_timing_pkg.sv
hdl/video_regs_pkg.sv
hdl/video_gen.sv
hdl/vram_arbiter.sv
hdl/vram.sv
hdl/font_ram.sv
hdl/text_video_top.sv
verif/text_video_properties.sv
verif/text_video_tb.sv
